// File: core_req_pkg.sv
// core-side widths and request types; dword size is legal for scalar requests only
`default_nettype none

package core_req_pkg;

    localparam int addr_w    = 17;
    localparam int byte_w    = 8;
    localparam int word_w    = 32;
    localparam int scalar_w  = 64;
    localparam int vec_bytes = 32;
    localparam int max_elems = 8;

    typedef logic [addr_w-1:0]             addr_t;
    typedef logic [word_w-1:0]             word_t;
    typedef logic [scalar_w-1:0]           scalar_t;
    typedef logic [vec_bytes*byte_w-1:0]   vec_t;
    typedef logic [$clog2(max_elems):0]    elem_len_t;   // 0..max_elems
    typedef logic [$clog2(max_elems)-1:0]  elem_idx_t;
    typedef logic [max_elems-1:0]          elem_mask_t;

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_half  = 2'd1,
        size_word  = 2'd2,
        size_dword = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        op_nop   = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } mem_op_e;

    // address step per cache beat, a dword moves in two word beats
    function automatic addr_t size_step(mem_size_e size);
        case (size)
            size_byte: return addr_t'(1);
            size_half: return addr_t'(2);
            default:   return addr_t'(4);
        endcase
    endfunction

endpackage

`default_nettype wire

// File: dcache_proto_pkg.sv
// cache command/status encodings and controller status; cache command is a one-cycle strobe
`default_nettype none

package dcache_proto_pkg;

    typedef enum logic [1:0] {
        cmd_nop   = 2'd0,
        cmd_load  = 2'd1,
        cmd_store = 2'd2
    } dcache_cmd_e;

    typedef enum logic [1:0] {
        dc_resting  = 2'd0,
        dc_busy     = 2'd1,
        dc_finished = 2'd2   // one cycle, load word valid
    } dcache_status_e;

    typedef enum logic [1:0] {
        ctrl_resting  = 2'd0,
        ctrl_working  = 2'd1,
        ctrl_stall    = 2'd2,
        ctrl_finished = 2'd3
    } ctrl_status_e;

    typedef enum logic [1:0] {
        seq_idle,
        seq_issue,
        seq_wait_beat
    } seq_state_e;

endpackage

`default_nettype wire

// File: mem_req_if.sv
// captured request plus sequencer progress; fields are stable only while valid is high
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;

    logic                     valid;
    core_req_pkg::mem_op_e    op;
    logic                     is_vector;
    core_req_pkg::mem_size_e  size;
    core_req_pkg::elem_len_t  length;
    logic                     vm;
    core_req_pkg::elem_mask_t mask;
    core_req_pkg::vec_t       wvec;
    core_req_pkg::scalar_t    wscalar;

    logic                     accept;   // sequencer idle, may capture
    logic                     done;
    core_req_pkg::elem_idx_t  elem;
    logic                     hi_beat;

    modport regs (output valid, op, is_vector, size, length, vm, mask, wvec, wscalar,
                  input accept, done);

    modport seq (input valid, op, is_vector, size, length, vm, mask,
                 output accept, done, elem, hi_beat);

    modport dp (input valid, op, is_vector, size, wvec, wscalar, elem, hi_beat);

endinterface

`default_nettype wire

// File: mem_request_regs.sv
// holds one core request from capture until the sequencer signals done; scalar length forced to 1
`timescale 1ns/1ps
`default_nettype none

module mem_request_regs (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           mem_access_enabled,
    input  wire core_req_pkg::mem_op_e    op,
    input  wire                           is_vector,
    input  wire core_req_pkg::mem_size_e  size,
    input  wire core_req_pkg::elem_len_t  length,
    input  wire                           vm,
    input  wire core_req_pkg::elem_mask_t mask,
    input  wire core_req_pkg::scalar_t    written_scalar_data,
    input  wire core_req_pkg::vec_t       written_vector_data,
    mem_req_if.regs                       req
);

    logic capture;

    assign capture = req.accept && mem_access_enabled;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.valid     <= 1'b0;
            req.op        <= core_req_pkg::op_nop;
            req.is_vector <= 1'b0;
            req.size      <= core_req_pkg::size_byte;
            req.length    <= '0;
            req.vm        <= 1'b0;
        end else if (capture) begin
            req.valid     <= 1'b1;
            req.op        <= op;
            req.is_vector <= is_vector;
            req.size      <= size;
            req.length    <= is_vector ? length : core_req_pkg::elem_len_t'(1);
            req.vm        <= vm;
        end else if (req.done) begin
            req.valid <= 1'b0;
        end
    end

    // payload loads on capture
    always_ff @(posedge clk) begin
        if (capture) begin
            req.mask    <= mask;
            req.wvec    <= written_vector_data;
            req.wscalar <= written_scalar_data;
        end
    end

endmodule

`default_nettype wire

// File: mem_access_fsm.sv
// walks elements and dword beats; one command per beat, issued only while the cache is resting
`timescale 1ns/1ps
`default_nettype none

module mem_access_fsm (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire core_req_pkg::addr_t             data_addr,
    input  wire dcache_proto_pkg::dcache_status_e dcache_status,
    mem_req_if.seq                               req,
    output dcache_proto_pkg::ctrl_status_e       ctrl_status,
    output dcache_proto_pkg::dcache_cmd_e        dcache_cmd,
    output core_req_pkg::addr_t                  cache_addr,
    output core_req_pkg::mem_size_e              cache_size
);

    dcache_proto_pkg::seq_state_e state;
    core_req_pkg::addr_t          addr_q;
    core_req_pkg::addr_t          step;
    core_req_pkg::elem_idx_t      elem_q;
    logic                         hi_q;
    logic                         fin_q;   // end-of-request marker

    logic finish_now;
    logic at_issue;
    logic active;
    logic cache_rest;
    logic cache_fin;
    logic dword;
    logic last_elem;
    logic beat_done;
    logic elem_end;
    logic stall;

    assign finish_now = (req.op == core_req_pkg::op_nop) || (req.length == '0);

    // first cycle after capture behaves as an issue cycle
    assign at_issue = (state == dcache_proto_pkg::seq_issue) ||
                      (state == dcache_proto_pkg::seq_idle && req.valid && !finish_now);

    assign active     = !req.is_vector || req.vm || req.mask[elem_q];
    assign cache_rest = dcache_status == dcache_proto_pkg::dc_resting;
    assign cache_fin  = dcache_status == dcache_proto_pkg::dc_finished;
    assign dword      = req.size == core_req_pkg::size_dword;
    assign step       = core_req_pkg::size_step(req.size);
    assign last_elem  = (core_req_pkg::elem_len_t'(elem_q) + 1'b1) == req.length;
    assign beat_done  = (state == dcache_proto_pkg::seq_wait_beat) && cache_fin;

    // masked element, or last beat of an active one
    assign elem_end = (at_issue && !active) || (beat_done && !(dword && !hi_q));

    assign stall = (at_issue && active && !cache_rest) ||
                   (state == dcache_proto_pkg::seq_wait_beat && !cache_fin);

    assign req.accept  = (state == dcache_proto_pkg::seq_idle) && !req.valid;
    assign req.done    = (elem_end && last_elem) ||
                         (state == dcache_proto_pkg::seq_idle && req.valid && finish_now);
    assign req.elem    = elem_q;
    assign req.hi_beat = hi_q;

    assign cache_addr = addr_q;
    assign cache_size = dword ? core_req_pkg::size_word : req.size;

    always_comb begin
        dcache_cmd = dcache_proto_pkg::cmd_nop;
        if (at_issue && active && cache_rest) begin
            dcache_cmd = (req.op == core_req_pkg::op_store) ? dcache_proto_pkg::cmd_store
                                                            : dcache_proto_pkg::cmd_load;
        end
    end

    always_comb begin
        if (fin_q) begin
            ctrl_status = dcache_proto_pkg::ctrl_finished;
        end else if (state == dcache_proto_pkg::seq_idle && !req.valid) begin
            ctrl_status = dcache_proto_pkg::ctrl_resting;
        end else if (state == dcache_proto_pkg::seq_idle && finish_now) begin
            ctrl_status = dcache_proto_pkg::ctrl_finished;   // nop or empty vector
        end else if (stall) begin
            ctrl_status = dcache_proto_pkg::ctrl_stall;
        end else begin
            ctrl_status = dcache_proto_pkg::ctrl_working;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= dcache_proto_pkg::seq_idle;
            addr_q <= '0;
            elem_q <= '0;
            hi_q   <= 1'b0;
            fin_q  <= 1'b0;
        end else begin
            fin_q <= 1'b0;
            if (req.accept) begin
                addr_q <= data_addr;   // follows the core until capture
                elem_q <= '0;
                hi_q   <= 1'b0;
            end
            if (at_issue && active) begin
                state <= cache_rest ? dcache_proto_pkg::seq_wait_beat
                                    : dcache_proto_pkg::seq_issue;
            end
            if (beat_done && dword && !hi_q) begin
                hi_q   <= 1'b1;
                addr_q <= addr_q + step;
                state  <= dcache_proto_pkg::seq_issue;
            end
            if (elem_end) begin
                hi_q   <= 1'b0;
                addr_q <= addr_q + step;   // masked elements step too
                elem_q <= elem_q + 1'b1;
                if (last_elem) begin
                    state <= dcache_proto_pkg::seq_idle;
                    fin_q <= 1'b1;
                end else begin
                    state <= dcache_proto_pkg::seq_issue;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: store_word_select.sv
// combinational write word; vector dword elements are not supported and fall back to word
`timescale 1ns/1ps
`default_nettype none

module store_word_select (
    mem_req_if.dp               req,
    output core_req_pkg::word_t cache_wdata
);

    localparam int hw = core_req_pkg::word_w;

    always_comb begin
        if (!req.is_vector) begin
            // dword scalar goes low half first
            cache_wdata = req.hi_beat ? req.wscalar[hw +: hw] : req.wscalar[0 +: hw];
        end else begin
            case (req.size)
                core_req_pkg::size_byte: begin
                    cache_wdata = core_req_pkg::word_t'(req.wvec[{req.elem, 3'b000} +: 8]);
                end
                core_req_pkg::size_half: begin
                    cache_wdata = core_req_pkg::word_t'(req.wvec[{req.elem, 4'b0000} +: 16]);
                end
                default: begin
                    cache_wdata = req.wvec[{req.elem, 5'b00000} +: hw];
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: load_data_assemble.sv
// load results update on the cache finish edge; vector lanes clear one cycle after capture
`timescale 1ns/1ps
`default_nettype none

module load_data_assemble (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire dcache_proto_pkg::dcache_status_e dcache_status,
    input  wire core_req_pkg::word_t             cache_rdata,
    mem_req_if.dp                                req,
    output core_req_pkg::scalar_t                scalar_data,
    output core_req_pkg::vec_t                   vector_data
);

    logic valid_q;
    logic is_load;
    logic load_done;
    logic new_vec_load;

    assign is_load      = req.valid && (req.op == core_req_pkg::op_load);
    assign load_done    = is_load && (dcache_status == dcache_proto_pkg::dc_finished);
    assign new_vec_load = is_load && !valid_q && req.is_vector;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            scalar_data <= '0;
            vector_data <= '0;
        end else begin
            valid_q <= req.valid;
            if (new_vec_load) begin
                vector_data <= '0;   // masked lanes stay zero
            end
            if (load_done && req.is_vector) begin
                case (req.size)
                    core_req_pkg::size_byte:
                        vector_data[{req.elem, 3'b000} +: 8] <= cache_rdata[7:0];
                    core_req_pkg::size_half:
                        vector_data[{req.elem, 4'b0000} +: 16] <= cache_rdata[15:0];
                    default:
                        vector_data[{req.elem, 5'b00000} +: 32] <= cache_rdata;
                endcase
            end
            if (load_done && !req.is_vector) begin
                case (req.size)
                    core_req_pkg::size_byte:
                        scalar_data <= {{56{cache_rdata[7]}}, cache_rdata[7:0]};
                    core_req_pkg::size_half:
                        scalar_data <= {{48{cache_rdata[15]}}, cache_rdata[15:0]};
                    core_req_pkg::size_word:
                        scalar_data <= {{32{cache_rdata[31]}}, cache_rdata};
                    default: begin
                        if (req.hi_beat) begin
                            scalar_data[63:32] <= cache_rdata;
                        end else begin
                            scalar_data[31:0] <= cache_rdata;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: mem_ctrl_top.sv
// core to data cache access controller; no handshake on the cache side beyond status levels
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   mem_access_enabled,
    input  wire core_req_pkg::mem_op_e            op,
    input  wire                                   is_vector,
    input  wire core_req_pkg::mem_size_e          size,
    input  wire core_req_pkg::addr_t              data_addr,
    input  wire core_req_pkg::elem_len_t          length,
    input  wire                                   vm,
    input  wire core_req_pkg::elem_mask_t         mask,
    input  wire core_req_pkg::scalar_t            written_scalar_data,
    input  wire core_req_pkg::vec_t               written_vector_data,
    input  wire dcache_proto_pkg::dcache_status_e dcache_status,
    input  wire core_req_pkg::word_t              cache_rdata,
    output wire dcache_proto_pkg::ctrl_status_e   ctrl_status,
    output wire core_req_pkg::scalar_t            scalar_data,
    output wire core_req_pkg::vec_t               vector_data,
    output wire dcache_proto_pkg::dcache_cmd_e    dcache_cmd,
    output wire core_req_pkg::addr_t              cache_addr,
    output wire core_req_pkg::mem_size_e          cache_size,
    output wire core_req_pkg::word_t              cache_wdata
);

    mem_req_if req ();

    mem_request_regs u_regs (
        .clk                 (clk),
        .rst_n               (rst_n),
        .mem_access_enabled  (mem_access_enabled),
        .op                  (op),
        .is_vector           (is_vector),
        .size                (size),
        .length              (length),
        .vm                  (vm),
        .mask                (mask),
        .written_scalar_data (written_scalar_data),
        .written_vector_data (written_vector_data),
        .req                 (req.regs)
    );

    mem_access_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_addr     (data_addr),
        .dcache_status (dcache_status),
        .req           (req.seq),
        .ctrl_status   (ctrl_status),
        .dcache_cmd    (dcache_cmd),
        .cache_addr    (cache_addr),
        .cache_size    (cache_size)
    );

    store_word_select u_wsel (
        .req         (req.dp),
        .cache_wdata (cache_wdata)
    );

    load_data_assemble u_load (
        .clk           (clk),
        .rst_n         (rst_n),
        .dcache_status (dcache_status),
        .cache_rdata   (cache_rdata),
        .req           (req.dp),
        .scalar_data   (scalar_data),
        .vector_data   (vector_data)
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// testbench clock and active-low reset; reset releases on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int period       = 8,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // away from the capture edge
    end

endmodule

`default_nettype wire

// File: tb_dcache_model.sv
// behavioural cache; 128 KiB byte memory, 0 to 3 busy cycles then one finished cycle
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_model (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire dcache_proto_pkg::dcache_cmd_e    dcache_cmd,
    input  wire core_req_pkg::addr_t              cache_addr,
    input  wire core_req_pkg::mem_size_e          cache_size,
    input  wire core_req_pkg::word_t              cache_wdata,
    output dcache_proto_pkg::dcache_status_e      dcache_status,
    output core_req_pkg::word_t                   cache_rdata
);

    logic [7:0]              mem [0:(1 << core_req_pkg::addr_w) - 1];
    core_req_pkg::addr_t     log_addr[$];
    core_req_pkg::mem_size_e log_size[$];
    core_req_pkg::word_t     log_data[$];
    int                      bad_cmds = 0;   // commands seen while not resting
    int                      wait_left;
    int                      n_wait;
    int                      n_bytes;
    core_req_pkg::word_t     word_now;
    core_req_pkg::word_t     hold;

    // fill mixes every address bit
    initial begin
        for (int a = 0; a < (1 << core_req_pkg::addr_w); a++) begin
            mem[a] = a[7:0] ^ a[15:8] ^ {7'b0, a[16]};
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dcache_status <= dcache_proto_pkg::dc_resting;
            cache_rdata   <= '0;
            wait_left     <= 0;
        end else begin
            if (dcache_cmd != dcache_proto_pkg::cmd_nop &&
                dcache_status != dcache_proto_pkg::dc_resting) begin
                bad_cmds <= bad_cmds + 1;
            end
            case (dcache_status)
                dcache_proto_pkg::dc_resting: begin
                    if (dcache_cmd != dcache_proto_pkg::cmd_nop) begin
                        n_wait  = int'($urandom % 32'd4);
                        n_bytes = (cache_size == core_req_pkg::size_byte) ? 1 :
                                  (cache_size == core_req_pkg::size_half) ? 2 : 4;
                        word_now = '0;
                        log_addr.push_back(cache_addr);
                        log_size.push_back(cache_size);
                        log_data.push_back(cache_wdata);
                        for (int k = 0; k < n_bytes; k++) begin
                            if (dcache_cmd == dcache_proto_pkg::cmd_store) begin
                                mem[cache_addr + k] <= cache_wdata[k*8 +: 8];
                            end else begin
                                word_now[k*8 +: 8] = mem[cache_addr + k];
                            end
                        end
                        hold <= word_now;
                        if (n_wait == 0) begin
                            dcache_status <= dcache_proto_pkg::dc_finished;
                            cache_rdata   <= word_now;
                        end else begin
                            dcache_status <= dcache_proto_pkg::dc_busy;
                            wait_left     <= n_wait - 1;
                        end
                    end
                end
                dcache_proto_pkg::dc_busy: begin
                    if (wait_left == 0) begin
                        dcache_status <= dcache_proto_pkg::dc_finished;
                        cache_rdata   <= hold;
                    end else begin
                        wait_left <= wait_left - 1;
                    end
                end
                default: dcache_status <= dcache_proto_pkg::dc_resting;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tb_mem_ctrl.sv
// directed tests for the access controller; one request at a time, vector elements up to 4 bytes
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ctrl;

    localparam int period     = 8;
    localparam int num_reqs   = 40;
    localparam int worst_wait = 3;
    localparam int margin     = 4;
    localparam int timeout_ns = num_reqs * 8 * 2 * (worst_wait + margin) * period + 32 * period;

    logic                             clk;
    logic                             rst_n;
    logic                             mem_access_enabled;
    core_req_pkg::mem_op_e            op;
    logic                             is_vector;
    core_req_pkg::mem_size_e          size;
    core_req_pkg::addr_t              data_addr;
    core_req_pkg::elem_len_t          length;
    logic                             vm;
    core_req_pkg::elem_mask_t         mask;
    core_req_pkg::scalar_t            written_scalar_data;
    core_req_pkg::vec_t               written_vector_data;
    dcache_proto_pkg::dcache_status_e dcache_status;
    core_req_pkg::word_t              cache_rdata;
    dcache_proto_pkg::ctrl_status_e   ctrl_status;
    core_req_pkg::scalar_t            scalar_data;
    core_req_pkg::vec_t               vector_data;
    dcache_proto_pkg::dcache_cmd_e    dcache_cmd;
    core_req_pkg::addr_t              cache_addr;
    core_req_pkg::mem_size_e          cache_size;
    core_req_pkg::word_t              cache_wdata;

    int                  errors = 0;
    core_req_pkg::addr_t exp_addrs[$];
    core_req_pkg::word_t exp_data[$];   // store words, one per command

    tb_clk_gen #(.period(period), .reset_cycles(16)) u_clk (.clk(clk), .rst_n(rst_n));

    mem_ctrl_top i_dut (
        .clk(clk), .rst_n(rst_n), .mem_access_enabled(mem_access_enabled), .op(op),
        .is_vector(is_vector), .size(size), .data_addr(data_addr), .length(length),
        .vm(vm), .mask(mask), .written_scalar_data(written_scalar_data),
        .written_vector_data(written_vector_data), .dcache_status(dcache_status),
        .cache_rdata(cache_rdata), .ctrl_status(ctrl_status), .scalar_data(scalar_data),
        .vector_data(vector_data), .dcache_cmd(dcache_cmd), .cache_addr(cache_addr),
        .cache_size(cache_size), .cache_wdata(cache_wdata)
    );

    tb_dcache_model i_cache (
        .clk(clk), .rst_n(rst_n), .dcache_cmd(dcache_cmd), .cache_addr(cache_addr),
        .cache_size(cache_size), .cache_wdata(cache_wdata),
        .dcache_status(dcache_status), .cache_rdata(cache_rdata)
    );

    task automatic check_equal(string name, logic [255:0] got, logic [255:0] exp);
        assert (got == exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic int elem_bytes(core_req_pkg::mem_size_e s);
        return (s == core_req_pkg::size_byte) ? 1 : (s == core_req_pkg::size_half) ? 2 : 4;
    endfunction

    // little-endian read of n bytes from the cache model
    function automatic logic [63:0] mem_val(core_req_pkg::addr_t a, int n);
        logic [63:0] v;
        v = '0;
        for (int k = n - 1; k >= 0; k--) begin
            v = {v[55:0], i_cache.mem[a + k]};
        end
        return v;
    endfunction

    function automatic core_req_pkg::vec_t exp_vec(core_req_pkg::addr_t a, int eb, int len,
                                                   logic vm_i, core_req_pkg::elem_mask_t m);
        core_req_pkg::vec_t v;
        v = '0;
        for (int i = 0; i < len; i++) begin
            if (vm_i || m[i]) begin
                for (int b = 0; b < eb; b++) begin
                    v[(i*eb + b)*8 +: 8] = i_cache.mem[a + i*eb + b];
                end
            end
        end
        return v;
    endfunction

    // drives one request, waits for finished, checks every command
    task automatic run_req(core_req_pkg::mem_op_e o, logic vec, core_req_pkg::mem_size_e s,
                           core_req_pkg::addr_t a, int len, logic vm_i,
                           core_req_pkg::elem_mask_t m, core_req_pkg::scalar_t wsc,
                           core_req_pkg::vec_t wv);
        int                      start;
        int                      n;
        int                      eb;
        core_req_pkg::word_t     w;
        core_req_pkg::mem_size_e exp_size;
        start = i_cache.log_addr.size();
        eb = elem_bytes(s);
        exp_size = (s == core_req_pkg::size_dword) ? core_req_pkg::size_word : s;
        exp_addrs.delete();
        exp_data.delete();
        if (o != core_req_pkg::op_nop && !vec) begin
            exp_addrs.push_back(a);
            exp_data.push_back(wsc[31:0]);
            if (s == core_req_pkg::size_dword) begin
                exp_addrs.push_back(core_req_pkg::addr_t'(a + 4));
                exp_data.push_back(wsc[63:32]);
            end
        end else if (o != core_req_pkg::op_nop) begin
            for (int i = 0; i < len; i++) begin
                if (vm_i || m[i]) begin
                    w = '0;
                    for (int b = 0; b < eb; b++) begin
                        w[b*8 +: 8] = wv[(i*eb + b)*8 +: 8];
                    end
                    exp_addrs.push_back(core_req_pkg::addr_t'(a + i * eb));
                    exp_data.push_back(w);
                end
            end
        end
        @(posedge clk);
        #1;
        op = o;
        is_vector = vec;
        size = s;
        data_addr = a;
        length = core_req_pkg::elem_len_t'(len);
        vm = vm_i;
        mask = m;
        written_scalar_data = wsc;
        written_vector_data = wv;
        mem_access_enabled = 1'b1;
        @(posedge clk);
        #1 mem_access_enabled = 1'b0;
        do @(negedge clk); while (ctrl_status != dcache_proto_pkg::ctrl_finished);
        @(negedge clk);
        assert (ctrl_status == dcache_proto_pkg::ctrl_resting) else begin
            $display("ctrl_status did not return to resting after one finished cycle");
            errors++;
        end
        n = i_cache.log_addr.size() - start;
        check_equal("command count", 256'(n), 256'(exp_addrs.size()));
        for (int i = 0; i < n && i < exp_addrs.size(); i++) begin
            check_equal("cache_addr", 256'(i_cache.log_addr[start + i]), 256'(exp_addrs[i]));
            check_equal("cache_size", 256'(i_cache.log_size[start + i]), 256'(exp_size));
            if (o == core_req_pkg::op_store) begin
                check_equal("cache_wdata", 256'(i_cache.log_data[start + i]),
                            256'(exp_data[i]));
            end
        end
    endtask

    task automatic scalar_loads();
        logic [63:0] v;
        v = mem_val('h80, 4);
        run_req(core_req_pkg::op_load, 0, core_req_pkg::size_word, 'h80, 1, 0, 0, 0, 0);
        check_equal("scalar_data", 256'(scalar_data), 256'({{32{v[31]}}, v[31:0]}));
        v = mem_val('h1f5, 1);
        run_req(core_req_pkg::op_load, 0, core_req_pkg::size_byte, 'h1f5, 1, 0, 0, 0, 0);
        check_equal("scalar_data", 256'(scalar_data), 256'({{56{v[7]}}, v[7:0]}));
        v = mem_val('h204, 8);
        run_req(core_req_pkg::op_load, 0, core_req_pkg::size_dword, 'h204, 1, 0, 0, 0, 0);
        check_equal("scalar_data", 256'(scalar_data), 256'(v));
    endtask

    task automatic scalar_stores();
        logic [63:0] above;
        run_req(core_req_pkg::op_store, 0, core_req_pkg::size_dword, 'h300, 1, 0, 0,
                64'h89ab_cdef_0123_4567, 0);
        check_equal("mem dword", 256'(mem_val('h300, 8)), 256'(64'h89ab_cdef_0123_4567));
        above = mem_val('h404, 4);
        run_req(core_req_pkg::op_store, 0, core_req_pkg::size_word, 'h400, 1, 0, 0,
                64'hdead_beef_cafe_f00d, 0);
        check_equal("mem word", 256'(mem_val('h400, 4)), 256'(32'hcafe_f00d));
        check_equal("mem above word", 256'(mem_val('h404, 4)), 256'(above));
    endtask

    task automatic vector_loads();
        core_req_pkg::mem_size_e s;
        core_req_pkg::addr_t     a;
        core_req_pkg::vec_t      want;
        for (int si = 0; si < 3; si++) begin
            for (int len = 1; len <= 8; len++) begin
                s = core_req_pkg::mem_size_e'(si);
                a = core_req_pkg::addr_t'('h1000 + si * 'h100 + len * 'h20 + si);
                want = exp_vec(a, elem_bytes(s), len, 1, 0);
                run_req(core_req_pkg::op_load, 1, s, a, len, 1, 8'($urandom), 0, 0);
                check_equal("vector_data", vector_data, want);
            end
        end
    endtask

    task automatic masked_accesses();
        core_req_pkg::vec_t wv;
        core_req_pkg::vec_t want;
        logic [7:0]         old_b [0:7];
        wv = {8{$urandom}};
        want = exp_vec('h2000, 2, 8, 0, 8'hb2);
        run_req(core_req_pkg::op_load, 1, core_req_pkg::size_half, 'h2000, 8, 0, 8'hb2, 0, 0);
        check_equal("vector_data", vector_data, want);
        for (int i = 0; i < 8; i++) begin
            old_b[i] = i_cache.mem['h2100 + i];
        end
        run_req(core_req_pkg::op_store, 1, core_req_pkg::size_byte, 'h2100, 8, 0, 8'h5c, 0, wv);
        for (int i = 0; i < 8; i++) begin
            check_equal("mem byte", 256'(i_cache.mem['h2100 + i]),
                        256'(8'h5c >> i & 1 ? wv[i*8 +: 8] : old_b[i]));
        end
        want = exp_vec('h2200, 4, 8, 1, 0);
        run_req(core_req_pkg::op_load, 1, core_req_pkg::size_word, 'h2200, 8, 1, 8'h00, 0, 0);
        check_equal("vector_data", vector_data, want);
    endtask

    task automatic empty_requests();
        run_req(core_req_pkg::op_nop, 0, core_req_pkg::size_word, 'h500, 1, 0, 0, 0, 0);
        run_req(core_req_pkg::op_load, 1, core_req_pkg::size_byte, 'h600, 0, 1, 0, 0, 0);
    endtask

    initial begin
        void'($urandom(32'h057c337e));
        mem_access_enabled  = 1'b0;
        op                  = core_req_pkg::op_nop;
        is_vector           = 1'b0;
        size                = core_req_pkg::size_byte;
        data_addr           = '0;
        length              = '0;
        vm                  = 1'b0;
        mask                = '0;
        written_scalar_data = '0;
        written_vector_data = '0;
        @(posedge rst_n);
        scalar_loads();
        scalar_stores();
        vector_loads();
        masked_accesses();
        empty_requests();
        assert (i_cache.bad_cmds == 0) else begin
            $display("command issued while the cache was not resting");
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: run did not complete within %0d ns", timeout_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
core_req_pkg.sv
dcache_proto_pkg.sv
mem_req_if.sv
mem_request_regs.sv
mem_access_fsm.sv
store_word_select.sv
load_data_assemble.sv
mem_ctrl_top.sv
tb_clk_gen.sv
tb_dcache_model.sv
tb_mem_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_mem_ctrl
FILELIST  ?= src.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
